//--- design/hdmi_display_pkg.sv
package hdmi_display_pkg;

    // coordinate widths of the 720p raster.
    localparam int X_BITS = 11;
    localparam int Y_BITS = 10;

    typedef logic [X_BITS-1:0] coord_x_t;  // active-area column.
    typedef logic [Y_BITS-1:0] coord_y_t;  // active-area row.
    typedef logic [7:0]        color8_t;
    typedef logic [15:0]       pix565_t;   // {b[4:0], g[5:0], r[4:0]}.

    // widened colour, one byte per component.
    typedef struct packed {
        color8_t r;
        color8_t g;
        color8_t b;
    } rgb888_t;

    // raster timing for one pixel position.
    // x and y read zero outside the active area.
    typedef struct packed {
        logic     hsync;
        logic     vsync;
        logic     de;
        logic     line_start;  // first active pixel of a line.
        coord_x_t x;
        coord_y_t y;
    } raster_t;

    // one output word for the TMDS encoder.
    typedef struct packed {
        raster_t raster;
        rgb888_t rgb;
    } disp_pack_t;

    typedef enum logic {
        WAIT_VSYNC,  // hold until the camera frame starts.
        RUN
    } timer_state_t;

endpackage : hdmi_display_pkg

//--- design/raster_timing_gen.sv
`timescale 1ns/1ps

module raster_timing_gen #(
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 322,
    parameter int H_SYNC = 12,
    parameter int H_BP   = 278,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 7,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 11
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        i_vsync,
    output hdmi_display_pkg::raster_t   o_raster
);

    import hdmi_display_pkg::*;

    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;
    localparam int H_W     = $clog2(H_TOTAL);
    localparam int V_W     = $clog2(V_TOTAL);

    // region boundaries in counter units.
    localparam logic [H_W-1:0] H_SYNC_BEG = H_W'(H_ACT + H_FP);
    localparam logic [H_W-1:0] H_SYNC_END = H_W'(H_ACT + H_FP + H_SYNC);
    localparam logic [H_W-1:0] H_LAST     = H_W'(H_TOTAL - 1);
    localparam logic [V_W-1:0] V_SYNC_BEG = V_W'(V_ACT + V_FP);
    localparam logic [V_W-1:0] V_SYNC_END = V_W'(V_ACT + V_FP + V_SYNC);
    localparam logic [V_W-1:0] V_LAST     = V_W'(V_TOTAL - 1);

    timer_state_t   state;
    logic           vsync_d;
    logic           vsync_rise;
    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_act;
    logic           v_act;
    raster_t        raster_nxt;

    assign vsync_rise = i_vsync && !vsync_d;

    // arm once on the first camera frame and free-run after.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d <= 1'b0;
            state   <= WAIT_VSYNC;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else begin
            vsync_d <= i_vsync;
            case (state)
                WAIT_VSYNC: begin
                    if (vsync_rise) begin
                        state <= RUN;
                        h_cnt <= '0;
                        v_cnt <= '0;
                    end
                end
                RUN: begin
                    // later vsync edges are not looked at.
                    if (h_cnt == H_LAST) begin
                        h_cnt <= '0;
                        if (v_cnt == V_LAST) begin
                            v_cnt <= '0;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= WAIT_VSYNC;
            endcase
        end
    end

    assign h_act = (h_cnt < H_W'(H_ACT));
    assign v_act = (v_cnt < V_W'(V_ACT));

    always_comb begin
        raster_nxt = '0;
        if (state == RUN) begin
            raster_nxt.hsync = (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
            raster_nxt.vsync = (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);  // whole lines.
            raster_nxt.de    = h_act && v_act;
            if (h_act && v_act) begin
                raster_nxt.line_start = (h_cnt == '0);
                raster_nxt.x          = coord_x_t'(h_cnt);
                raster_nxt.y          = coord_y_t'(v_cnt);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_raster <= '0;
        end else begin
            o_raster <= raster_nxt;
        end
    end

    // sync lies in the blanking interval and never inside the picture.
    a_hsync_not_de: assert property (
        @(posedge clk) disable iff (!rstn)
        !(o_raster.hsync && o_raster.de)
    ) else $error("hsync overlaps de");

    a_x_in_range: assert property (
        @(posedge clk) disable iff (!rstn)
        o_raster.de |-> (o_raster.x < H_ACT)
    ) else $error("x out of active range");

    a_line_start_de: assert property (
        @(posedge clk) disable iff (!rstn)
        o_raster.line_start |-> o_raster.de
    ) else $error("line_start outside de");

endmodule : raster_timing_gen

//--- design/rgb565_expand.sv
`timescale 1ns/1ps

module rgb565_expand (
    input  logic                        clk,
    input  logic                        rstn,
    input  hdmi_display_pkg::pix565_t   i_data,
    output hdmi_display_pkg::rgb888_t   o_rgb
);

    import hdmi_display_pkg::*;

    pix565_t    pix_q;
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_q <= '0;
        end else begin
            pix_q <= i_data;  // no de gating.
        end
    end

    assign r5 = pix_q[4:0];
    assign g6 = pix_q[10:5];
    assign b5 = pix_q[15:11];

    // repeat the high bits so full scale maps to 255.
    assign o_rgb.r = {r5, r5[4:2]};
    assign o_rgb.g = {g6, g6[5:4]};
    assign o_rgb.b = {b5, b5[4:2]};

    a_red_full: assert property (
        @(posedge clk) disable iff (!rstn)
        (i_data[4:0] == 5'h1f) |=> (o_rgb.r == 8'hff)
    ) else $error("red full scale lost");

    a_green_full: assert property (
        @(posedge clk) disable iff (!rstn)
        (i_data[10:5] == 6'h3f) |=> (o_rgb.g == 8'hff)
    ) else $error("green full scale lost");

    a_blue_full: assert property (
        @(posedge clk) disable iff (!rstn)
        (i_data[15:11] == 5'h1f) |=> (o_rgb.b == 8'hff)
    ) else $error("blue full scale lost");

endmodule : rgb565_expand

//--- design/hdmi_pack.sv
`timescale 1ns/1ps

module hdmi_pack (
    input  logic                            clk,
    input  logic                            rstn,
    input  hdmi_display_pkg::raster_t       i_raster,
    input  hdmi_display_pkg::rgb888_t       i_rgb,
    output hdmi_display_pkg::disp_pack_t    o_pack
);

    import hdmi_display_pkg::*;

    disp_pack_t pack_nxt;

    // colour rides with the timing of the same cycle.
    always_comb begin
        pack_nxt        = '0;
        pack_nxt.raster = i_raster;
        pack_nxt.rgb    = i_rgb;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pack <= '0;  // encoder sees a blank word.
        end else begin
            o_pack <= pack_nxt;
        end
    end

    // rows are only numbered inside the picture.
    a_y_zero_blank: assert property (
        @(posedge clk) disable iff (!rstn)
        !o_pack.raster.de |-> (o_pack.raster.y == '0)
    ) else $error("y nonzero while de low");

endmodule : hdmi_pack

//--- design/hdmi_display.sv
`timescale 1ns/1ps

module hdmi_display #(
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 322,
    parameter int H_SYNC = 12,
    parameter int H_BP   = 278,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 7,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 11
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_vsync,
    input  logic                            i_href,  // reserved for line-locked mode.
    input  hdmi_display_pkg::pix565_t       i_data,
    output hdmi_display_pkg::disp_pack_t    o_pack
);

    import hdmi_display_pkg::*;

    raster_t raster;
    rgb888_t rgb;

    // active sizes must fit the coordinate fields.
    if (H_ACT > (1 << $bits(coord_x_t))) begin : g_bad_h_act
        $error("H_ACT does not fit coord_x_t");
    end
    if (V_ACT > (1 << $bits(coord_y_t))) begin : g_bad_v_act
        $error("V_ACT does not fit coord_y_t");
    end

    raster_timing_gen #(
        .H_ACT  (H_ACT ),
        .H_FP   (H_FP  ),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP  ),
        .V_ACT  (V_ACT ),
        .V_FP   (V_FP  ),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP  )
    ) u_timing (
        .clk      (clk    ),
        .rstn     (rstn   ),
        .i_vsync  (i_vsync),
        .o_raster (raster )
    );

    rgb565_expand u_expand (
        .clk    (clk   ),
        .rstn   (rstn  ),
        .i_data (i_data),
        .o_rgb  (rgb   )
    );

    hdmi_pack u_pack (
        .clk      (clk   ),
        .rstn     (rstn  ),
        .i_raster (raster),
        .i_rgb    (rgb   ),
        .o_pack   (o_pack)
    );

endmodule : hdmi_display

//--- tb/tb_display_model.svh
`ifndef TB_DISPLAY_MODEL_SVH
`define TB_DISPLAY_MODEL_SVH

// display pipeline model that steps once per rising edge.
logic     m_armed;
logic     m_vsync_d;
int       m_h;
int       m_v;
raster_t  m_stage1;  // timing register of the DUT.
raster_t  m_stage2;  // raster part of o_pack.
logic     m_live1;
logic     m_live2;
rgb888_t  m_rgb_q[$];
rgb888_t  m_exp_rgb;

function automatic raster_t predict_raster(input int h, input int v);
    raster_t r;
    logic    h_act;
    logic    v_act;
    r       = '0;
    h_act   = (h < H_ACT);
    v_act   = (v < V_ACT);
    r.hsync = (h >= H_ACT + H_FP) && (h < H_ACT + H_FP + H_SYNC);
    r.vsync = (v >= V_ACT + V_FP) && (v < V_ACT + V_FP + V_SYNC);
    r.de    = h_act && v_act;
    if (r.de) begin
        r.line_start = (h == 0);
        r.x          = coord_x_t'(h);
        r.y          = coord_y_t'(v);
    end
    return r;
endfunction

// scale to 8 bits as v * 2^k plus its own top bits.
function automatic rgb888_t widen_565(input pix565_t p);
    rgb888_t res;
    color8_t r8;
    color8_t g8;
    color8_t b8;
    r8    = {3'b000, p[4:0]};
    g8    = {2'b00, p[10:5]};
    b8    = {3'b000, p[15:11]};
    res.r = (r8 << 3) | (r8 >> 2);
    res.g = (g8 << 2) | (g8 >> 4);
    res.b = (b8 << 3) | (b8 >> 2);
    return res;
endfunction

task automatic model_reset();
    rgb888_t blank;
    blank     = '0;
    m_armed   = 1'b0;
    m_vsync_d = 1'b0;
    m_h       = 0;
    m_v       = 0;
    m_stage1  = '0;
    m_stage2  = '0;
    m_live1   = 1'b0;
    m_live2   = 1'b0;
    m_exp_rgb = '0;
    m_rgb_q.delete();
    m_rgb_q.push_back(blank);  // pixel register clears to zero.
endtask

task automatic model_step(input logic vs, input pix565_t d);
    m_stage2 = m_stage1;
    m_live2  = m_live1;
    if (m_armed) begin
        m_stage1 = predict_raster(m_h, m_v);
    end else begin
        m_stage1 = '0;
    end
    m_live1 = m_armed;
    m_rgb_q.push_back(widen_565(d));
    m_exp_rgb = m_rgb_q.pop_front();
    if (m_armed) begin
        if (m_h == H_TOTAL - 1) begin
            m_h = 0;
            m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
        end else begin
            m_h = m_h + 1;
        end
    end else if (vs && !m_vsync_d) begin
        m_armed = 1'b1;  // first frame start only.
        m_h     = 0;
        m_v     = 0;
    end
    m_vsync_d = vs;
endtask

task automatic value_error(input string name, input string exp_s, input string act_s);
    fail_run($sformatf("** Error at %0d ns: %s expected %s, got %s",
                       $time, name, exp_s, act_s));
endtask

task automatic check_raster(input raster_t exp, input raster_t act);
    if (act.hsync !== exp.hsync) begin
        value_error("o_pack.raster.hsync", $sformatf("%0d", exp.hsync),
                    $sformatf("%0d", act.hsync));
    end
    if (act.vsync !== exp.vsync) begin
        value_error("o_pack.raster.vsync", $sformatf("%0d", exp.vsync),
                    $sformatf("%0d", act.vsync));
    end
    if (act.de !== exp.de) begin
        value_error("o_pack.raster.de", $sformatf("%0d", exp.de), $sformatf("%0d", act.de));
    end
    if (act.line_start !== exp.line_start) begin
        value_error("o_pack.raster.line_start", $sformatf("%0d", exp.line_start),
                    $sformatf("%0d", act.line_start));
    end
    if (act.x !== exp.x) begin
        value_error("o_pack.raster.x", $sformatf("%0d", exp.x), $sformatf("%0d", act.x));
    end
    if (act.y !== exp.y) begin
        value_error("o_pack.raster.y", $sformatf("%0d", exp.y), $sformatf("%0d", act.y));
    end
endtask

task automatic check_rgb(input rgb888_t exp, input rgb888_t act);
    if (act.r !== exp.r) begin
        value_error("o_pack.rgb.r", $sformatf("%02h", exp.r), $sformatf("%02h", act.r));
    end
    if (act.g !== exp.g) begin
        value_error("o_pack.rgb.g", $sformatf("%02h", exp.g), $sformatf("%02h", act.g));
    end
    if (act.b !== exp.b) begin
        value_error("o_pack.rgb.b", $sformatf("%02h", exp.b), $sformatf("%02h", act.b));
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        value_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    end
endtask

`endif

//--- tb/tb_hdmi_display.sv
`timescale 1ns/1ps

module tb_hdmi_display;

    import hdmi_display_pkg::*;

    // small raster so that whole frames run in a few hundred cycles.
    localparam int H_ACT  = 8;
    localparam int H_FP   = 2;
    localparam int H_SYNC = 2;
    localparam int H_BP   = 3;
    localparam int V_ACT  = 4;
    localparam int V_FP   = 1;
    localparam int V_SYNC = 1;
    localparam int V_BP   = 2;

    localparam int H_TOTAL       = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL       = V_ACT + V_FP + V_SYNC + V_BP;
    localparam int FRAME         = H_TOTAL * V_TOTAL;
    localparam int RUN_POSITIONS = 3 * FRAME;                 // three frames after arming.
    localparam int CYCLE_LIMIT   = 2 * (RUN_POSITIONS + 60);

    logic        clk;
    logic        rstn;
    logic        i_vsync;
    logic        i_href;
    pix565_t     i_data;
    disp_pack_t  o_pack;

    logic [31:0] rng_state;
    int          vs_gap;       // low cycles left before the next pulse.
    int          vs_high;      // high cycles left in the current pulse.
    logic        first_pulse;
    int          drive_idx;
    int          cycles;
    int          positions;    // raster positions seen on o_pack since arming.
    int          de_total;
    int          ls_total;
    int          hs_total;
    int          vs_total;
    int          hs_line;
    int          de_frame;

    hdmi_display #(
        .H_ACT  (H_ACT ),
        .H_FP   (H_FP  ),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP  ),
        .V_ACT  (V_ACT ),
        .V_FP   (V_FP  ),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP  )
    ) u_dut (
        .clk     (clk    ),
        .rstn    (rstn   ),
        .i_vsync (i_vsync),
        .i_href  (i_href ),
        .i_data  (i_data ),
        .o_pack  (o_pack )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped on failure");
    endtask

    `include "tb_display_model.svh"

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // camera vsync has one long gap and a 3-cycle frame pulse before stray pulses.
    task automatic drive_inputs();
        logic [31:0] rnd;
        rnd = next_rand();
        if (vs_gap > 0) begin
            i_vsync = 1'b0;
            vs_gap--;
            if (vs_gap == 0) begin
                vs_high     = first_pulse ? 3 : 1 + int'(rnd[1:0]);
                first_pulse = 1'b0;
            end
        end else begin
            i_vsync = 1'b1;
            vs_high--;
            if (vs_high == 0) begin
                vs_gap = 30 + int'(rnd[13:8]);
            end
        end
        rnd = next_rand();
        case (drive_idx % 16)
            5:       i_data = 16'hffff;
            13:      i_data = 16'h0000;
            default: i_data = rnd[15:0];
        endcase
        i_href = rnd[16];
        drive_idx++;
    endtask

    task automatic tally_position();
        raster_t first_pos;
        int      h_pos;
        h_pos = positions % H_TOTAL;
        if (positions == 0) begin
            first_pos            = '0;  // top-left pixel of the frame.
            first_pos.de         = 1'b1;
            first_pos.line_start = 1'b1;
            check_raster(first_pos, o_pack.raster);
        end
        if (o_pack.raster.hsync) begin
            hs_total++;
            hs_line++;
        end
        if (o_pack.raster.de) begin
            de_total++;
            de_frame++;
        end
        if (o_pack.raster.vsync) vs_total++;
        if (o_pack.raster.line_start) ls_total++;
        if (h_pos == H_TOTAL - 1) begin
            check_count("hsync cycles in line", H_SYNC, hs_line);
            hs_line = 0;
        end
        if (positions % FRAME == FRAME - 1) begin
            check_count("de cycles in frame", H_ACT * V_ACT, de_frame);
            de_frame = 0;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        fail_run($sformatf("timeout: cycle limit of %0d reached before the run finished",
                           CYCLE_LIMIT));
    end

    initial begin
        rstn        = 1'b0;
        i_vsync     = 1'b0;
        i_href      = 1'b0;
        i_data      = '0;
        rng_state   = 32'heb7c;
        first_pulse = 1'b1;
        vs_high     = 0;
        drive_idx   = 0;
        positions   = 0;
        de_total    = 0;
        ls_total    = 0;
        hs_total    = 0;
        vs_total    = 0;
        hs_line     = 0;
        de_frame    = 0;
        vs_gap      = 10 + int'(next_rand() % 32'd31);
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        while (positions < RUN_POSITIONS) begin
            @(posedge clk);
            model_step(i_vsync, i_data);
            #1;
            check_raster(m_stage2, o_pack.raster);
            check_rgb(m_exp_rgb, o_pack.rgb);
            if (m_live2) begin
                tally_position();
                positions++;
            end
            drive_inputs();
        end
        check_count("de cycles in run", 3 * H_ACT * V_ACT, de_total);
        check_count("line_start pulses in run", 3 * V_ACT, ls_total);
        check_count("hsync cycles in run", 3 * V_TOTAL * H_SYNC, hs_total);
        check_count("vsync cycles in run", 3 * V_SYNC * H_TOTAL, vs_total);
        $display("All tests passed!");
        $finish;
    end

endmodule : tb_hdmi_display

//--- hdmi_display.f
+incdir+tb
design/hdmi_display_pkg.sv
design/raster_timing_gen.sv
design/rgb565_expand.sv
design/hdmi_pack.sv
design/hdmi_display.sv
tb/tb_hdmi_display.sv

//--- Makefile
# Verilator build and run of the HDMI display testbench.

TOP  := tb_hdmi_display
BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard design/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes.
$(BIN): hdmi_display.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f hdmi_display.f

# exit status is nonzero when the testbench stops on $fatal.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
